// File: source/serdes_test_params.svh
// ----------------------------------------------------------
// sizes and register map of the test-pattern transmitter,
// included by every file that needs them
// ----------------------------------------------------------

`ifndef SERDES_TEST_PARAMS_SVH
`define SERDES_TEST_PARAMS_SVH

`define WORD_WIDTH 10
`define FRAME_BITS 12
`define PRBS_WIDTH 31
`define SLOT_COUNT 16

`define REG_CTRL   4'h0
`define REG_SEED   4'h4
`define REG_FIXED  4'h8
`define REG_FRAMES 4'hC

`endif

// File: source/serdes_test_pkg.sv
// ----------------------------------------------------------
// types shared by the serializer test-pattern transmitter:
// pattern modes, slot kinds, serializer states and the
// register address type
// ----------------------------------------------------------

package serdes_test_pkg;

	typedef logic [3:0] reg_addr_t; // AXI4-Lite byte address

	typedef enum logic [1:0] {
		MODE_SEQUENCE = 2'd0, // full 16-slot sequence
		MODE_PRBS     = 2'd1, // random word in every slot
		MODE_FIXED    = 2'd2  // fixed-word register in every slot
	} pattern_mode_e;

	typedef enum logic [2:0] {
		SLOT_ONES      = 3'd0,
		SLOT_RAMP      = 3'd1, // ones shifted right by slot number
		SLOT_ZEROS     = 3'd2,
		SLOT_ALTERNATE = 3'd3, // 0x155
		SLOT_RANDOM    = 3'd4, // low bits of the lfsr
		SLOT_IDLE      = 3'd5  // fixed word from the register
	} slot_kind_e;

	typedef enum logic [1:0] {
		SER_IDLE  = 2'd0,
		SER_START = 2'd1,
		SER_DATA  = 2'd2,
		SER_STOP  = 2'd3
	} ser_state_e;

endpackage

// File: source/word_if.sv
// ----------------------------------------------------------
// one pattern word with valid/ready handshake and sync tag,
// passed from the sequencer to the frame serializer
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "serdes_test_params.svh"

interface word_if;

	logic                   valid;
	logic                   ready;
	logic [`WORD_WIDTH-1:0] data;
	logic                   sync; // word belongs to slot 0

	modport source (
		output valid, data, sync,
		input  ready
	);

	modport sink (
		input  valid, data, sync,
		output ready
	);

endinterface

// File: source/axi_lite_regs.sv
// ----------------------------------------------------------
// AXI4-Lite slave with the control, seed and fixed-word
// registers plus a read-only count of finished frames
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "serdes_test_params.svh"

module axi_lite_regs (
	input  logic                              clock,
	input  logic                              reset,
	input  serdes_test_pkg::reg_addr_t        awaddr,
	input  logic                              awvalid,
	output logic                              awready,
	input  logic [31:0]                       wdata,
	input  logic [3:0]                        wstrb,
	input  logic                              wvalid,
	output logic                              wready,
	output logic [1:0]                        bresp,
	output logic                              bvalid,
	input  logic                              bready,
	input  serdes_test_pkg::reg_addr_t        araddr,
	input  logic                              arvalid,
	output logic                              arready,
	output logic [31:0]                       rdata,
	output logic [1:0]                        rresp,
	output logic                              rvalid,
	input  logic                              rready,
	input  logic                              frame_done,
	output logic                              enable,
	output serdes_test_pkg::pattern_mode_e    mode,
	output logic [`PRBS_WIDTH-1:0]            seed,
	output logic                              seed_load,
	output logic [`WORD_WIDTH-1:0]            fixed_word
);
	import serdes_test_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic        write_fire;
	logic        read_fire;
	logic [31:0] ctrl_merged;
	logic [31:0] seed_merged;
	logic [31:0] fixed_merged;
	logic [31:0] frame_count;
	logic [31:0] read_value;

	function automatic logic [31:0] merge_bytes(input logic [31:0] current,
			input logic [31:0] value, input logic [3:0] strobe);
		logic [31:0] result;
		result = current;
		for (int i = 0; i < 4; i++) begin
			if (strobe[i])
				result[8*i +: 8] = value[8*i +: 8];
		end
		return result;
	endfunction

	assign write_fire = awvalid && awready; // wready pulses alongside
	assign read_fire  = arvalid && arready;
	assign bresp      = RESP_OKAY;
	assign rresp      = RESP_OKAY;

	always_comb begin
		ctrl_merged  = merge_bytes({29'd0, mode, enable}, wdata, wstrb);
		seed_merged  = merge_bytes({1'b0, seed}, wdata, wstrb);
		fixed_merged = merge_bytes({22'd0, fixed_word}, wdata, wstrb);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			awready     <= 1'b0;
			wready      <= 1'b0;
			bvalid      <= 1'b0;
			enable      <= 1'b0;
			mode        <= MODE_SEQUENCE;
			seed        <= `PRBS_WIDTH'(1);
			seed_load   <= 1'b0;
			fixed_word  <= '0;
			frame_count <= '0;
		end else begin
			awready   <= awvalid && wvalid && !awready && !bvalid;
			wready    <= awvalid && wvalid && !awready && !bvalid;
			seed_load <= 1'b0;
			if (write_fire) begin
				bvalid <= 1'b1;
				case (awaddr)
					`REG_CTRL: begin
						enable <= ctrl_merged[0];
						mode   <= pattern_mode_e'(ctrl_merged[2:1]);
					end
					`REG_SEED: begin
						// an all-zero lfsr would never leave zero
						if (seed_merged[`PRBS_WIDTH-1:0] == '0)
							seed <= `PRBS_WIDTH'(1);
						else
							seed <= seed_merged[`PRBS_WIDTH-1:0];
						seed_load <= 1'b1;
					end
					`REG_FIXED: fixed_word <= fixed_merged[`WORD_WIDTH-1:0];
					default: ; // FRAMES is read only
				endcase
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (frame_done)
				frame_count <= frame_count + 32'd1;
		end
	end

	always_comb begin
		case (araddr)
			`REG_CTRL:   read_value = {29'd0, mode, enable};
			`REG_SEED:   read_value = {1'b0, seed};
			`REG_FIXED:  read_value = {22'd0, fixed_word};
			`REG_FRAMES: read_value = frame_count;
			default:     read_value = '0; // unmapped reads as zero
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (read_fire)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (read_fire)
			rdata <= read_value; // held until rready
	end

endmodule

// File: source/prbs_generator.sv
// ----------------------------------------------------------
// 31-bit lfsr (x^31 + x^28 + 1) for the random pattern words;
// loaded from the seed register, advanced one step on request
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "serdes_test_params.svh"

module prbs_generator (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`PRBS_WIDTH-1:0] seed,
	input  logic                   seed_load,
	input  logic                   step,
	output logic [`PRBS_WIDTH-1:0] word
);

	logic [`PRBS_WIDTH-1:0] lfsr;
	logic                   feedback;

	assign feedback = lfsr[30] ^ lfsr[27]; // taps for x^31 + x^28
	assign word     = lfsr;

	always_ff @(posedge clock) begin
		if (reset) begin
			lfsr <= `PRBS_WIDTH'(1);
		end else if (seed_load) begin
			lfsr <= seed; // a new seed wins over a step
		end else if (step) begin
			lfsr <= {lfsr[`PRBS_WIDTH-2:0], feedback};
		end
	end

endmodule

// File: source/pattern_sequencer.sv
// ----------------------------------------------------------
// picks the pattern word for each of the 16 slots and offers
// it to the serializer; one word waits here while the
// previous one is being shifted out
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "serdes_test_params.svh"

module pattern_sequencer (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           enable,
	input  serdes_test_pkg::pattern_mode_e mode,
	input  logic [`WORD_WIDTH-1:0]         fixed_word,
	input  logic [`PRBS_WIDTH-1:0]         prbs_word,
	output logic                           prbs_step,
	word_if.source                         words
);
	import serdes_test_pkg::*;

	localparam int SLOT_BITS = $clog2(`SLOT_COUNT);

	logic [SLOT_BITS-1:0]   slot; // slot of the offered word, or the next one
	logic [SLOT_BITS-1:0]   next_slot;
	slot_kind_e             next_kind;
	logic [`WORD_WIDTH-1:0] next_word;
	logic                   accept;
	logic                   load;

	assign accept    = words.valid && words.ready;
	assign next_slot = accept ? slot + 1'b1 : slot;
	assign load      = enable && (!words.valid || accept);
	assign prbs_step = load && (next_kind == SLOT_RANDOM); // stalls hold the lfsr

	always_comb begin
		case (mode)
			MODE_PRBS:  next_kind = SLOT_RANDOM;
			MODE_FIXED: next_kind = SLOT_IDLE;
			default: begin
				if (next_slot == 0)
					next_kind = SLOT_ONES; // sync word
				else if (next_slot <= 9)
					next_kind = SLOT_RAMP;
				else if (next_slot == 10)
					next_kind = SLOT_ZEROS;
				else if (next_slot == 11)
					next_kind = SLOT_ALTERNATE;
				else if (next_slot == 12)
					next_kind = SLOT_RANDOM;
				else
					next_kind = SLOT_ONES;
			end
		endcase
	end

	always_comb begin
		case (next_kind)
			SLOT_RAMP:      next_word = {`WORD_WIDTH{1'b1}} >> next_slot;
			SLOT_ZEROS:     next_word = '0;
			SLOT_ALTERNATE: next_word = `WORD_WIDTH'('h155);
			SLOT_RANDOM:    next_word = prbs_word[`WORD_WIDTH-1:0];
			SLOT_IDLE:      next_word = fixed_word;
			default:        next_word = '1;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			slot        <= '0;
			words.valid <= 1'b0;
			words.sync  <= 1'b0;
		end else begin
			if (accept)
				slot <= slot + 1'b1;
			if (load) begin
				words.valid <= 1'b1;
				words.sync  <= (next_slot == 0); // slot 0 tags sync in every mode
			end else if (accept) begin
				words.valid <= 1'b0; // enable cleared, pending word gone
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load)
			words.data <= next_word;
	end

endmodule

// File: source/frame_serializer.sv
// ----------------------------------------------------------
// sends each accepted word as a 12-bit line frame: start bit
// 1, data lsb first, stop bit 0; ready in idle and at the
// stop bit so frames can run back to back
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "serdes_test_params.svh"

module frame_serializer (
	input  logic   clock,
	input  logic   reset,
	word_if.sink   words,
	output logic   serial_out,
	output logic   sync,
	output logic   frame_done
);
	import serdes_test_pkg::*;

	localparam int COUNT_BITS = $clog2(`WORD_WIDTH);
	localparam int LAST_BIT   = `FRAME_BITS - 3; // frame minus start, stop, zero base

	ser_state_e              state;
	logic [COUNT_BITS-1:0]   bit_count;
	logic [`WORD_WIDTH-1:0]  shifter;
	logic                    sync_tag;
	logic                    accept;

	assign words.ready = (state == SER_IDLE) || (state == SER_STOP);
	assign accept      = words.valid && words.ready;
	assign frame_done  = (state == SER_STOP);
	assign sync        = (state == SER_START) && sync_tag;

	always_comb begin
		case (state)
			SER_START: serial_out = 1'b1;
			SER_DATA:  serial_out = shifter[0];
			default:   serial_out = 1'b0; // idle line and stop bit
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= SER_IDLE;
			bit_count <= '0;
		end else begin
			case (state)
				SER_IDLE: begin
					if (accept)
						state <= SER_START;
				end
				SER_START: begin
					state     <= SER_DATA;
					bit_count <= '0;
				end
				SER_DATA: begin
					if (bit_count == COUNT_BITS'(LAST_BIT))
						state <= SER_STOP;
					else
						bit_count <= bit_count + 1'b1;
				end
				SER_STOP: state <= accept ? SER_START : SER_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			shifter  <= words.data;
			sync_tag <= words.sync;
		end else if (state == SER_DATA) begin
			shifter <= shifter >> 1; // next bit into position 0
		end
	end

endmodule

// File: source/serdes_test_top.sv
// ----------------------------------------------------------
// test-pattern transmitter top: AXI4-Lite control port in,
// framed serial pattern and sync pulse out
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "serdes_test_params.svh"

module serdes_test_top (
	input  logic                       clock,
	input  logic                       reset,
	input  serdes_test_pkg::reg_addr_t awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [31:0]                wdata,
	input  logic [3:0]                 wstrb,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  serdes_test_pkg::reg_addr_t araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [31:0]                rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready,
	output logic                       serial_out,
	output logic                       sync
);
	import serdes_test_pkg::*;

	logic                   enable;
	pattern_mode_e          mode;
	logic [`PRBS_WIDTH-1:0] seed;
	logic                   seed_load;
	logic [`WORD_WIDTH-1:0] fixed_word;
	logic [`PRBS_WIDTH-1:0] prbs_word;
	logic                   prbs_step;
	logic                   frame_done;

	word_if words ();

	axi_lite_regs regs (
		.clock(clock), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.frame_done(frame_done),
		.enable(enable), .mode(mode), .seed(seed), .seed_load(seed_load),
		.fixed_word(fixed_word)
	);

	prbs_generator prbs (
		.clock(clock), .reset(reset),
		.seed(seed), .seed_load(seed_load), .step(prbs_step),
		.word(prbs_word)
	);

	pattern_sequencer sequencer (
		.clock(clock), .reset(reset),
		.enable(enable), .mode(mode), .fixed_word(fixed_word),
		.prbs_word(prbs_word), .prbs_step(prbs_step),
		.words(words)
	);

	frame_serializer serializer (
		.clock(clock), .reset(reset),
		.words(words),
		.serial_out(serial_out), .sync(sync), .frame_done(frame_done)
	);

endmodule

// File: bench/serdes_test_assert.sv
// ----------------------------------------------------------
// handshake and line assertions, bound into frame_serializer
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "serdes_test_params.svh"

module serdes_test_assert (
	input logic                   clock,
	input logic                   reset,
	input logic                   valid,
	input logic                   ready,
	input logic [`WORD_WIDTH-1:0] data,
	input logic                   word_sync,
	input logic                   sync,
	input logic                   serial_out
);

	localparam int SYNC_GAP = `FRAME_BITS * `SLOT_COUNT; // one sync word per 16 frames

	int failure_count = 0;
	int since_sync; // cycles since the last sync pulse, saturating

	always @(posedge clock) begin
		if (reset)
			since_sync <= SYNC_GAP;
		else if (sync)
			since_sync <= 1;
		else if (since_sync < SYNC_GAP)
			since_sync <= since_sync + 1;
	end

	stalled_word_stable: assert property (@(posedge clock) disable iff (reset)
		valid && !ready |=> valid && $stable(data) && $stable(word_sync))
	else begin
		failure_count++;
		$error("word changed or was withdrawn while the serializer stalled");
	end

	sync_once_per_sequence: assert property (@(posedge clock) disable iff (reset)
		sync |-> since_sync >= SYNC_GAP)
	else begin
		failure_count++;
		$error("sync longer than one cycle or repeated within one sequence");
	end

	line_low_in_reset: assert property (@(posedge clock) reset |=> !serial_out)
	else begin
		failure_count++;
		$error("serial_out not low after a reset edge");
	end

endmodule

bind frame_serializer serdes_test_assert checks (
	.clock(clock), .reset(reset),
	.valid(words.valid), .ready(words.ready),
	.data(words.data), .word_sync(words.sync),
	.sync(sync), .serial_out(serial_out)
);

// File: bench/serdes_test_checker.sv
// ----------------------------------------------------------
// watches serial_out and sync, rebuilds each 12-bit frame and
// compares it with the slot rules and a local lfsr model
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "serdes_test_params.svh"

module serdes_test_checker (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           serial_out,
	input  logic                           sync,
	input  logic                           quiet,
	input  serdes_test_pkg::pattern_mode_e mode,
	input  logic [`WORD_WIDTH-1:0]         fixed_word,
	input  logic [`PRBS_WIDTH-1:0]         seed,
	input  logic                           seed_load,
	output int                             frame_total,
	output int                             error_count,
	output logic                           in_frame
);
	import serdes_test_pkg::*;

	int                     position; // 0 waits for start, 1..10 data, 11 stop
	int                     slot;
	logic [`WORD_WIDTH-1:0] received;
	logic [`WORD_WIDTH-1:0] expected;
	logic [`PRBS_WIDTH-1:0] lfsr_model;

	function automatic logic random_slot(input pattern_mode_e m, input int s);
		return (m == MODE_PRBS) || (m == MODE_SEQUENCE && s == 12);
	endfunction

	function automatic logic [`WORD_WIDTH-1:0] slot_word(input pattern_mode_e m, input int s,
			input logic [`PRBS_WIDTH-1:0] lfsr, input logic [`WORD_WIDTH-1:0] fixed);
		if (m == MODE_FIXED)
			return fixed;
		if (random_slot(m, s))
			return lfsr[`WORD_WIDTH-1:0];
		if (s >= 1 && s <= 9)
			return {`WORD_WIDTH{1'b1}} >> s; // ramp down
		if (s == 10)
			return '0;
		if (s == 11)
			return `WORD_WIDTH'('h155);
		return '1;
	endfunction

	// x^31 + x^28 + 1, shifting left
	function automatic logic [`PRBS_WIDTH-1:0] lfsr_advance(input logic [`PRBS_WIDTH-1:0] v);
		return {v[`PRBS_WIDTH-2:0], v[30] ^ v[27]};
	endfunction

	assign in_frame = (position != 0);

	always @(negedge clock) begin
		if (reset) begin
			position    = 0;
			frame_total = 0;
			error_count = 0;
			lfsr_model  = `PRBS_WIDTH'(1);
		end else begin
			slot = frame_total % `SLOT_COUNT;
			if (seed_load)
				lfsr_model = seed;
			if (sync && !(position == 0 && serial_out)) begin
				$display("sync high at %0t outside a start bit", $time);
				error_count++;
			end
			if (position == 0) begin
				if (serial_out) begin // start bit
					if (quiet) begin
						$display("start bit at %0t while the line should be idle", $time);
						error_count++;
					end
					if (sync !== (slot == 0)) begin
						$display("FAILED sync at slot %0d: got 0x%h expected 0x%h",
							slot, sync, (slot == 0));
						error_count++;
					end
					position = 1;
				end
			end else if (position <= `WORD_WIDTH) begin
				received[position-1] = serial_out; // lsb first
				position++;
			end else begin
				expected = slot_word(mode, slot, lfsr_model, fixed_word);
				if (serial_out !== 1'b0) begin
					$display("FAILED serial_out stop bit: got 0x%h expected 0x0", serial_out);
					error_count++;
				end
				if (received !== expected) begin
					$display("FAILED serial_out word in slot %0d: got 0x%h expected 0x%h",
						slot, received, expected);
					error_count++;
				end
				if (random_slot(mode, slot))
					lfsr_model = lfsr_advance(lfsr_model);
				frame_total++;
				position = 0;
			end
		end
	end

endmodule

// File: bench/serdes_test_tb.sv
// ----------------------------------------------------------
// testbench for the test-pattern transmitter: replays the
// register trace, runs pattern bursts, prints the summary
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "serdes_test_params.svh"

module serdes_test_tb;
	import serdes_test_pkg::*;

	localparam int ACCESS_CYCLES = 20;
	localparam int FRAME_CYCLES  = 14;
	localparam int MARGIN_CYCLES = 200;

	logic clock, reset, awvalid, wvalid, bready, arvalid, rready;
	logic awready, wready, bvalid, arready, rvalid, serial_out, sync;
	reg_addr_t   awaddr, araddr;
	logic [31:0] wdata, rdata;
	logic [3:0]  wstrb;
	logic [1:0]  bresp, rresp;

	pattern_mode_e          mode; // register state as seen by the checker
	logic [`WORD_WIDTH-1:0] fixed_word;
	logic [`PRBS_WIDTH-1:0] seed;
	logic                   seed_load;
	logic                   quiet; // line must stay idle
	logic                   in_frame;
	int                     frame_total;
	int                     error_count;
	int                     reg_errors;
	int                     limit_cycles;
	logic                   trace_ready;
	logic                   trace_ok;
	logic [7:0]             kinds[$];
	logic [31:0]            first_args[$];
	logic [31:0]            second_args[$];

	serdes_test_top UUT (.*);
	serdes_test_checker frame_check (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic step_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = 1'b1;
		do
			step_cycle();
		while (!awready); // handshake on the next edge
		if (wready !== 1'b1) begin
			$display("FAILED wready: got 0x%h expected 0x1", wready);
			reg_errors++;
		end
		step_cycle();
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			step_cycle();
		if (bresp !== 2'b00) begin
			$display("FAILED bresp: got 0x%h expected 0x0", bresp);
			reg_errors++;
		end
		step_cycle();
		bready = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
		araddr  = addr;
		arvalid = 1'b1;
		rready  = 1'b1;
		do
			step_cycle();
		while (!arready);
		step_cycle();
		arvalid = 1'b0;
		while (!rvalid)
			step_cycle();
		data = rdata;
		if (rresp !== 2'b00) begin
			$display("FAILED rresp: got 0x%h expected 0x0", rresp);
			reg_errors++;
		end
		step_cycle();
		rready = 1'b0;
	endtask

	task automatic check_read(input logic [3:0] addr, input logic [31:0] expected);
		logic [31:0] value;
		read_reg(addr, value);
		if (value !== expected) begin
			$display("FAILED rdata at 0x%h: got 0x%h expected 0x%h", addr, value, expected);
			reg_errors++;
		end
	endtask

	task automatic apply_write(input logic [3:0] addr, input logic [31:0] data);
		write_reg(addr, data);
		case (addr)
			`REG_CTRL: mode = pattern_mode_e'(data[2:1]); // enable belongs to run commands
			`REG_FIXED: fixed_word = data[`WORD_WIDTH-1:0];
			`REG_SEED: begin
				seed      = data[`PRBS_WIDTH-1:0];
				if (seed == '0)
					seed = `PRBS_WIDTH'(1); // zero seed is stored as 1
				seed_load = 1'b1;
				step_cycle();
				seed_load = 1'b0;
			end
			default: ;
		endcase
	endtask

	task automatic run_frames(input int count);
		int          target;
		int          last_total;
		int          tries;
		logic [31:0] frames_read;
		quiet  = 1'b0;
		target = frame_total + count;
		write_reg(`REG_CTRL, {29'd0, mode, 1'b1});
		while (frame_total < target)
			step_cycle();
		write_reg(`REG_CTRL, {29'd0, mode, 1'b0});
		tries = 0;
		do begin
			last_total = frame_total;
			repeat (3 * `FRAME_BITS) step_cycle();
			tries++;
		end while ((frame_total != last_total || in_frame) && tries < 8);
		if (frame_total != last_total || in_frame) begin
			$display("line did not fall idle after enable was cleared");
			reg_errors++;
		end
		quiet = 1'b1;
		read_reg(`REG_FRAMES, frames_read);
		if (frames_read !== frame_total) begin
			$display("FAILED rdata FRAMES: got 0x%h expected 0x%h", frames_read, frame_total);
			reg_errors++;
		end
	endtask

	task automatic load_trace();
		int             fd;
		int             code;
		int             accesses;
		int             frames;
		logic [63:0]    word;
		logic [2047:0]  rest;
		logic [31:0]    a;
		logic [31:0]    b;
		accesses = 0;
		frames   = 0;
		trace_ok = 1'b1;
		fd = $fopen("bench/serdes_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open the trace file bench/serdes_trace.txt");
			trace_ok = 1'b0;
		end else begin
			while ($fscanf(fd, "%s", word) == 1) begin
				if (word == "#") begin
					code = $fgets(rest, fd);
				end else if (word == "w" || word == "r") begin
					code = $fscanf(fd, "%h %h", a, b);
					if (code != 2) begin
						$display("register command in the trace file lacks its values");
						trace_ok = 1'b0;
					end
					kinds.push_back(word[7:0]);
					first_args.push_back(a);
					second_args.push_back(b);
					accesses++;
				end else if (word == "run") begin
					code = $fscanf(fd, "%d", a);
					if (code != 1) begin
						$display("run command in the trace file lacks its frame count");
						trace_ok = 1'b0;
					end
					kinds.push_back("n");
					first_args.push_back(a);
					second_args.push_back('0);
					accesses += 3;
					frames += int'(a) + 8; // tail frames and drain
				end else begin
					$display("unknown command in the trace file");
					trace_ok = 1'b0;
				end
			end
			$fclose(fd);
		end
		limit_cycles = 10 + accesses * ACCESS_CYCLES + frames * FRAME_CYCLES + MARGIN_CYCLES;
		trace_ready  = 1'b1;
	endtask

	initial begin
		int total;
		reset       = 1'b1;
		awaddr      = '0;
		awvalid     = 1'b0;
		wdata       = '0;
		wstrb       = '0;
		wvalid      = 1'b0;
		bready      = 1'b0;
		araddr      = '0;
		arvalid     = 1'b0;
		rready      = 1'b0;
		mode        = MODE_SEQUENCE;
		fixed_word  = '0;
		seed        = `PRBS_WIDTH'(1);
		seed_load   = 1'b0;
		quiet       = 1'b1;
		reg_errors  = 0;
		trace_ready = 1'b0;
		load_trace();
		if (!trace_ok) begin
			$display("FAIL: see errors above");
			$finish;
		end else begin
			repeat (10) @(posedge clock);
			#1;
			reset = 1'b0;
			for (int i = 0; i < kinds.size(); i++) begin
				case (kinds[i])
					"w":     apply_write(first_args[i][3:0], second_args[i]);
					"r":     check_read(first_args[i][3:0], second_args[i]);
					default: run_frames(int'(first_args[i]));
				endcase
			end
			repeat (5) step_cycle();
			total = reg_errors + error_count + UUT.serializer.checks.failure_count;
			$display("errors: register %0d, frame %0d, assertion %0d, total %0d (%0d frames)",
				reg_errors, error_count, UUT.serializer.checks.failure_count, total,
				frame_total);
			if (total == 0)
				$display("PASS: all tests");
			else
				$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		wait (trace_ready === 1'b1);
		repeat (limit_cycles) @(posedge clock);
		$display("timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: bench/serdes_trace.txt
# columns: command, register address (hex), value (hex); w writes, r reads and compares
# run <frames> enables the pattern, waits for that many frames, stops and checks FRAMES
# reset values
r 0 00000000
r 4 00000001
r 8 00000000
r c 00000000
# register write and read back
w 8 000002a5
r 8 000002a5
w 4 00000000
r 4 00000001
w 4 8badf00d
r 4 0badf00d
w 0 00000000
r 0 00000000
# full sequence, three passes
run 48
r 0 00000000
# random words from a new seed
w 4 12345678
w 0 00000002
r 0 00000002
run 20
# fixed word in every slot
w 0 00000004
run 16
r 4 12345678
r 8 000002a5

// File: list.f
+incdir+source
source/serdes_test_pkg.sv
source/word_if.sv
source/axi_lite_regs.sv
source/prbs_generator.sv
source/pattern_sequencer.sv
source/frame_serializer.sv
source/serdes_test_top.sv
bench/serdes_test_assert.sv
bench/serdes_test_checker.sv
bench/serdes_test_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the serializer test-pattern testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module serdes_test_tb \
	--Mdir obj_dir -o serdes_test_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

output=$(./obj_dir/serdes_test_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
